//--- common/irda_pkg.sv
package irda_pkg;

	// opening and closing flag
	localparam logic [7:0] MIR_FLAG = 8'h7e;

	// remainder left in the reflected CRC register after payload plus FCS
	localparam logic [15:0] CRC_RESIDUE = 16'hf0b8;

	localparam int WORD_W = 32;     // output word width
	localparam int LEN_W = 16;      // frame length field, in bytes
	localparam int ABORT_ONES = 7;  // run of ones taken as an abort

	// bit strobe divider used by the top level
	localparam int DEF_CLKS_PER_BIT = 4;

	typedef enum logic [2:0] {
		RX_IDLE, // hunting for a flag
		RX_FLAG, // flag seen, skipping repeated flags
		RX_FILL, // first sixteen bits into the delay line
		RX_DATA, // payload out of the delay line
		RX_END   // closing flag seen
	} rx_state_t;

endpackage

//--- common/mir_rx_if.sv
`timescale 1ns/1ns
interface mir_rx_if;
	import irda_pkg::*;

	// control to core
	logic bit_en;
	logic restart;

	// core to control
	logic [WORD_W-1:0] word;
	logic word_add;
	logic sto;          // frame end
	logic crc_error;
	logic [LEN_W-1:0] len;
	logic brk;          // abort while in a frame

	modport core (input bit_en, restart, output word, word_add, sto, crc_error, len, brk);
	modport ctrl (output bit_en, restart, input word, word_add, sto, crc_error, len, brk);

endinterface

//--- irda_mir_rx/irda_mir_line_det.sv
`timescale 1ns/1ns
module irda_mir_line_det (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic rx_i,
	input  logic bit_en_i,
	input  logic restart_i,
	output logic bit_o,
	output logic flag_o,
	output logic abort_o
);
	import irda_pkg::*;

	localparam int RUN_W = $clog2(ABORT_ONES);
	localparam logic [RUN_W-1:0] RUN_MAX = RUN_W'(ABORT_ONES - 1);

	logic rx_meta;
	logic rx_sync;
	logic [7:0] win_q;        // win_q[0] is the newest sampled bit
	logic [RUN_W-1:0] ones_q; // ones seen before the current sample

	// two flops against metastability
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			win_q  <= '1;
			ones_q <= '0;
		end else if (restart_i) begin
			win_q  <= '1; // all ones cannot fake a flag
			ones_q <= '0;
		end else if (bit_en_i) begin
			win_q <= {win_q[6:0], rx_sync};
			if (!rx_sync)
				ones_q <= '0;
			else if (ones_q != RUN_MAX)
				ones_q <= ones_q + 1'b1; // saturates
		end
	end

	// both detectors look at the sample being taken now
	assign flag_o  = ({win_q[6:0], rx_sync} == MIR_FLAG);
	assign abort_o = rx_sync && (ones_q == RUN_MAX);

	// bit leaving the window, eight bit times behind the line
	assign bit_o = win_q[7];

endmodule

//--- irda_mir_rx/irda_mir_bit_destuffer.sv
`timescale 1ns/1ns
module irda_mir_bit_destuffer (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic bit_i,
	input  logic bit_en_i,
	input  logic restart_i,
	output logic data_bit_o,
	output logic bit_o
);

	localparam logic [2:0] STUFF_ONES = 3'd5;

	logic [2:0] ones_q; // consecutive ones before bit_i

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ones_q <= '0;
		end else if (restart_i) begin
			ones_q <= '0;
		end else if (bit_en_i) begin
			if (!bit_i)
				ones_q <= '0;
			else if (ones_q != 3'd7)
				ones_q <= ones_q + 1'b1;
		end
	end

	// a zero right after five ones was inserted by the sender
	assign data_bit_o = bit_i || (ones_q != STUFF_ONES);
	assign bit_o      = bit_i;

endmodule

//--- irda_mir_rx/irda_crc_rx_ccitt16.sv
`timescale 1ns/1ns
module irda_crc_rx_ccitt16 (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic clear_i,
	input  logic bit_en_i,
	input  logic data_bit_i,
	input  logic bit_i,
	output logic [15:0] crc_o
);

	// x^16 + x^12 + x^5 + 1, bit reversed for lsb first data
	localparam logic [15:0] POLY_REV = 16'h8408;

	logic fb;

	assign fb = crc_o[0] ^ bit_i;

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			crc_o <= '1;
		end else if (clear_i) begin
			crc_o <= '1; // preset for next frame
		end else if (bit_en_i && data_bit_i) begin
			crc_o <= {1'b0, crc_o[15:1]} ^ (fb ? POLY_REV : 16'h0000);
		end
	end

endmodule

//--- irda_mir_rx/irda_mir_rx.sv
`timescale 1ns/1ns
module irda_mir_rx (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic rx_i,
	mir_rx_if.core mir
);
	import irda_pkg::*;

	localparam int POS_W = $clog2(WORD_W);

	rx_state_t state_q;
	logic [3:0] cnt_q;             // flag skip and fill counter
	logic [15:0] dly_q;            // holds back the FCS
	logic [WORD_W-1:0] pack_q;
	logic [WORD_W-1:0] pack_nxt;
	logic [WORD_W-1:0] word_q;
	logic [POS_W-1:0] pos_q;       // next free bit in pack_q
	logic [LEN_W+2:0] bits_q;      // payload bits in this frame
	logic word_add_q;
	logic ld_bit;
	logic ld_flag;
	logic ld_abort;
	logic dst_bit;
	logic dst_data;
	logic [15:0] crc;
	logic in_frame;
	logic abort_act;
	logic clr;
	logic shift_dly;
	logic shift_pack;
	logic word_full;
	logic word_emit;

	irda_mir_line_det u_line_det (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.rx_i      (rx_i),
		.bit_en_i  (mir.bit_en),
		.restart_i (mir.restart),
		.bit_o     (ld_bit),
		.flag_o    (ld_flag),
		.abort_o   (ld_abort)
	);

	irda_mir_bit_destuffer u_destuff (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.bit_i      (ld_bit),
		.bit_en_i   (mir.bit_en),
		.restart_i  (clr),
		.data_bit_o (dst_data),
		.bit_o      (dst_bit)
	);

	irda_crc_rx_ccitt16 u_crc (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.clear_i    (state_q == RX_IDLE || state_q == RX_FLAG),
		.bit_en_i   (mir.bit_en),
		.data_bit_i (dst_data && in_frame),
		.bit_i      (dst_bit),
		.crc_o      (crc)
	);

	assign in_frame  = (state_q == RX_FILL) || (state_q == RX_DATA);
	assign abort_act = mir.bit_en && ld_abort && (state_q != RX_IDLE);
	assign clr       = mir.restart || abort_act;

	assign shift_dly  = mir.bit_en && dst_data && in_frame;
	assign shift_pack = mir.bit_en && dst_data && (state_q == RX_DATA);
	assign word_full  = shift_pack && (pos_q == '1);
	// full word, or a partial one at the closing flag if it holds any bit
	assign word_emit  = word_full || (mir.bit_en && (state_q == RX_DATA) && ld_flag &&
		(shift_pack || pos_q != '0));

	always_comb begin
		pack_nxt = pack_q;
		if (shift_pack)
			pack_nxt[pos_q] = dly_q[15]; // lsb first
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_q <= RX_IDLE;
			cnt_q   <= '0;
			dly_q   <= '0;
			pack_q  <= '0;
			pos_q   <= '0;
			bits_q  <= '0;
		end else if (clr) begin
			state_q <= RX_IDLE;
			cnt_q   <= '0;
			dly_q   <= '0;
			pack_q  <= '0;
			pos_q   <= '0;
		end else if (mir.bit_en) begin
			if (shift_dly)
				dly_q <= {dly_q[14:0], dst_bit};
			if (shift_pack) begin
				pos_q  <= pos_q + 1'b1;
				pack_q <= word_full ? '0 : pack_nxt;
				bits_q <= bits_q + 1'b1;
			end
			case (state_q)
				RX_IDLE: begin
					if (ld_flag) begin
						state_q <= RX_FLAG;
						cnt_q   <= 4'd7;
					end
				end
				RX_FLAG: begin
					// the flag itself still has to leave the window
					if (cnt_q != 4'd0) begin
						cnt_q <= cnt_q - 1'b1;
					end else if (ld_flag) begin
						cnt_q <= 4'd7; // back to back flag
					end else begin
						state_q <= RX_FILL;
						cnt_q   <= 4'd15;
						bits_q  <= '0;
					end
				end
				RX_FILL: begin
					if (ld_flag) begin
						state_q <= RX_END; // runt frame
					end else if (dst_data) begin
						if (cnt_q == 4'd0)
							state_q <= RX_DATA;
						else
							cnt_q <= cnt_q - 1'b1;
					end
				end
				RX_DATA: begin
					if (ld_flag) begin
						state_q <= RX_END;
						pos_q   <= '0;
						pack_q  <= '0;
					end
				end
				RX_END:  state_q <= RX_IDLE;
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			word_add_q <= 1'b0;
		else
			word_add_q <= word_emit && !clr;
	end

	always_ff @(posedge clk) begin
		if (word_emit)
			word_q <= pack_nxt;
	end

	assign mir.word      = word_q;
	assign mir.word_add  = word_add_q;
	assign mir.sto       = mir.bit_en && (state_q == RX_END) && !clr;
	assign mir.crc_error = (crc != CRC_RESIDUE);
	assign mir.len       = bits_q[LEN_W+2:3]; // bits to bytes
	assign mir.brk       = abort_act;

endmodule

//--- rtl/irda_mir_ctrl.sv
`timescale 1ns/1ns
module irda_mir_ctrl #(
	parameter int CLKS_PER_BIT = irda_pkg::DEF_CLKS_PER_BIT
) (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic rx_en_i,
	input  logic restart_i,
	mir_rx_if.ctrl mir,
	output logic [irda_pkg::WORD_W-1:0] word_o,
	output logic word_valid_o,
	output logic frame_done_o,
	output logic crc_error_o,
	output logic [irda_pkg::LEN_W-1:0] frame_len_o,
	output logic break_o
);

	localparam int DIV_W = $clog2(CLKS_PER_BIT);

	logic [DIV_W-1:0] div_q;
	logic bit_en_q;
	logic restart_q;

	// bit strobe, held off while reception is disabled
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			div_q    <= '0;
			bit_en_q <= 1'b0;
		end else if (!rx_en_i) begin
			div_q    <= '0;
			bit_en_q <= 1'b0;
		end else if (div_q == DIV_W'(CLKS_PER_BIT - 1)) begin
			div_q    <= '0;
			bit_en_q <= 1'b1;
		end else begin
			div_q    <= div_q + 1'b1;
			bit_en_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			restart_q    <= 1'b0;
			frame_done_o <= 1'b0;
			crc_error_o  <= 1'b0;
			frame_len_o  <= '0;
			break_o      <= 1'b0;
		end else begin
			restart_q    <= restart_i;
			frame_done_o <= mir.sto;
			if (restart_i) begin
				crc_error_o <= 1'b0;
				frame_len_o <= '0;
				break_o     <= 1'b0;
			end else begin
				if (mir.sto) begin
					crc_error_o <= mir.crc_error;
					frame_len_o <= mir.len;
				end
				if (mir.brk)
					break_o <= 1'b1;      // sticky
				else if (mir.sto)
					break_o <= 1'b0;      // a completed frame clears it
			end
		end
	end

	assign mir.bit_en  = bit_en_q;
	assign mir.restart = restart_q;

	assign word_o       = mir.word;
	assign word_valid_o = mir.word_add;

endmodule

//--- rtl/irda_mir_rx_top.sv
`timescale 1ns/1ns
module irda_mir_rx_top #(
	parameter int CLKS_PER_BIT = irda_pkg::DEF_CLKS_PER_BIT
) (
	input  logic clk,
	input  logic wb_rst_i,
	input  logic rx_i,
	input  logic rx_en_i,
	input  logic restart_i,
	output logic [31:0] word_o,
	output logic word_valid_o,
	output logic frame_done_o,
	output logic crc_error_o,
	output logic [15:0] frame_len_o,
	output logic break_o
);

	mir_rx_if mir ();

	irda_mir_ctrl #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_ctrl (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.rx_en_i      (rx_en_i),
		.restart_i    (restart_i),
		.mir          (mir.ctrl),
		.word_o       (word_o),
		.word_valid_o (word_valid_o),
		.frame_done_o (frame_done_o),
		.crc_error_o  (crc_error_o),
		.frame_len_o  (frame_len_o),
		.break_o      (break_o)
	);

	irda_mir_rx u_rx (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.rx_i     (rx_i),
		.mir      (mir.core)
	);

endmodule

//--- tb/irda_mir_rx_sva.sv
`timescale 1ns/1ns
module irda_mir_rx_sva (
	input logic clk,
	input logic wb_rst_i,
	input logic word_add,
	input logic sto,
	input logic brk,
	input irda_pkg::rx_state_t state
);
	import irda_pkg::*;

	// last word goes out one bit time before the frame end
	word_vs_sto: assert property (@(posedge clk) disable iff (wb_rst_i) !(word_add && sto))
		else $error("word strobe and frame end in the same cycle");

	// an abort drops the frame whatever state it came in
	brk_to_idle: assert property (@(posedge clk) disable iff (wb_rst_i)
		brk |=> state == RX_IDLE)
		else $error("receiver did not return to idle after an abort");

	sto_to_idle: assert property (@(posedge clk) disable iff (wb_rst_i)
		sto |=> state == RX_IDLE)
		else $error("receiver did not return to idle after frame end");

endmodule

bind irda_mir_rx irda_mir_rx_sva u_sva (
	.clk      (clk),
	.wb_rst_i (wb_rst_i),
	.word_add (word_add_q),
	.sto      (mir.sto),
	.brk      (abort_act),
	.state    (state_q)
);

//--- tb/irda_mir_rx_tb.sv
`timescale 1ns/1ns
module irda_mir_rx_tb;
	import irda_pkg::*;

	localparam int CLKS_PER_BIT = 4;

	logic clk;
	logic wb_rst_i;
	logic rx_i;
	logic rx_en_i;
	logic restart_i;
	logic [31:0] word_o;
	logic word_valid_o;
	logic frame_done_o;
	logic crc_error_o;
	logic [15:0] frame_len_o;
	logic break_o;

	// stimulus table, one entry per test
	string t_name[$];
	int t_bytes[$];
	bit t_ones[$];      // payload all 0xff instead of random
	bit t_bad_fcs[$];
	int t_cut[$];       // byte where the frame is broken off, -1 for a full frame
	bit t_restart[$];   // broken off by a restart pulse rather than an abort
	bit t_en[$];
	bit t_exp_crc[$];
	bit t_exp_brk[$];

	logic [31:0] lcg_q = 32'd11;
	bit frame_bits[$];
	logic [7:0] payload[$];
	logic [31:0] got_words[$];
	int done_cnt = 0;
	int errors = 0;
	int failed_tests = 0;
	int cycles = 0;
	int limit = 0;

	irda_mir_rx_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.rx_i         (rx_i),
		.rx_en_i      (rx_en_i),
		.restart_i    (restart_i),
		.word_o       (word_o),
		.word_valid_o (word_valid_o),
		.frame_done_o (frame_done_o),
		.crc_error_o  (crc_error_o),
		.frame_len_o  (frame_len_o),
		.break_o      (break_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (word_valid_o)
			got_words.push_back(word_o);
		if (frame_done_o)
			done_cnt++;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the frame sequence never finished", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [7:0] lcg_next();
		lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
		return lcg_q[23:16];
	endfunction

	// reflected CCITT16, data lsb first
	function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		c = crc;
		for (int i = 0; i < 8; i++)
			c = (c[0] ^ b[i]) ? ((c >> 1) ^ 16'h8408) : (c >> 1);
		return c;
	endfunction

	task automatic add_row(input string name, input int nbytes, input bit ones,
		input bit bad_fcs, input int cut, input bit restart, input bit en,
		input bit exp_crc, input bit exp_brk);
		t_name.push_back(name);
		t_bytes.push_back(nbytes);
		t_ones.push_back(ones);
		t_bad_fcs.push_back(bad_fcs);
		t_cut.push_back(cut);
		t_restart.push_back(restart);
		t_en.push_back(en);
		t_exp_crc.push_back(exp_crc);
		t_exp_brk.push_back(exp_brk);
	endtask

	task automatic put_flag();
		for (int j = 0; j < 8; j++)
			frame_bits.push_back(MIR_FLAG[j]);
	endtask

	task automatic build_frame(input int n);
		logic [15:0] fcs;
		logic [7:0] b;
		int nraw;
		int ones;
		fcs = 16'hffff;
		payload.delete();
		frame_bits.delete();
		for (int i = 0; i < t_bytes[n]; i++) begin
			payload.push_back(t_ones[n] ? 8'hff : lcg_next());
			fcs = crc_byte(fcs, payload[i]);
		end
		fcs = ~fcs;
		if (t_bad_fcs[n])
			fcs[0] = ~fcs[0];
		repeat (8) frame_bits.push_back(1'b1); // idle line
		put_flag();
		put_flag();
		nraw = (t_cut[n] >= 0) ? t_cut[n] : t_bytes[n] + 2;
		ones = 0;
		for (int i = 0; i < nraw; i++) begin
			b = (i < t_bytes[n]) ? payload[i] : ((i == t_bytes[n]) ? fcs[7:0] : fcs[15:8]);
			for (int j = 0; j < 8; j++) begin
				frame_bits.push_back(b[j]);
				ones = b[j] ? ones + 1 : 0;
				if (ones == 5) begin
					frame_bits.push_back(1'b0); // stuffed zero
					ones = 0;
				end
			end
		end
		if (t_cut[n] < 0)
			put_flag();
		else if (!t_restart[n])
			repeat (ABORT_ONES) frame_bits.push_back(1'b1);
	endtask

	// one bit period on the line, with an optional one cycle restart pulse
	task automatic send_bit(input logic b, input logic rst);
		rx_i <= b;
		restart_i <= rst;
		@(posedge clk);
		restart_i <= 1'b0;
		repeat (CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	task automatic compare(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s %s: expected %h, got %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic run_test(input int n);
		int errs0;
		int done0;
		int words0;
		int nwords;
		bit exp_done;
		logic [31:0] exp_word;
		errs0 = errors;
		done0 = done_cnt;
		words0 = got_words.size();
		exp_done = (t_cut[n] < 0) && t_en[n];
		nwords = exp_done ? (t_bytes[n] + 3) / 4 : 0;
		build_frame(n);
		rx_en_i <= t_en[n];
		foreach (frame_bits[i])
			send_bit(frame_bits[i], 1'b0);
		if (t_cut[n] >= 0 && t_restart[n])
			send_bit(1'b1, 1'b1);
		if (exp_done)
			while (done_cnt == done0)
				send_bit(1'b1, 1'b0);
		repeat (16) send_bit(1'b1, 1'b0); // late or extra strobes show up here
		compare(t_name[n], "frame_done pulses", 32'(exp_done), 32'(done_cnt - done0));
		compare(t_name[n], "word count", 32'(nwords), 32'(got_words.size() - words0));
		for (int w = 0; w < nwords && words0 + w < got_words.size(); w++) begin
			exp_word = '0; // unfilled high bytes stay zero
			for (int k = 0; k < 4; k++)
				if (4 * w + k < t_bytes[n])
					exp_word[8*k +: 8] = payload[4*w+k];
			compare(t_name[n], $sformatf("word %0d", w), exp_word, got_words[words0+w]);
		end
		if (exp_done) begin
			compare(t_name[n], "crc_error_o", 32'(t_exp_crc[n]), 32'(crc_error_o));
			compare(t_name[n], "frame_len_o", 32'(t_bytes[n]), 32'(frame_len_o));
		end
		compare(t_name[n], "break_o", 32'(t_exp_brk[n]), 32'(break_o));
		if (errors == errs0) begin
			$display("test %s: ok", t_name[n]);
		end else begin
			$display("test %s: %0d mismatches", t_name[n], errors - errs0);
			failed_tests++;
		end
	endtask

	initial begin
		int total_bits;
		//      name              bytes ff fcs cut rst en crc brk
		add_row("rand3",           3,   0, 0,  -1, 0,  1, 0,  0);
		add_row("ones10",          10,  1, 0,  -1, 0,  1, 0,  0);
		add_row("bad_fcs",         8,   0, 1,  -1, 0,  1, 1,  0);
		add_row("abort",           6,   0, 0,  3,  0,  1, 0,  1);
		add_row("after_abort",     5,   0, 0,  -1, 0,  1, 0,  0);
		add_row("restart",         6,   0, 0,  3,  1,  1, 0,  0);
		add_row("after_restart",   4,   0, 0,  -1, 0,  1, 0,  0);
		add_row("disabled",        4,   0, 0,  -1, 0,  0, 0,  0);
		add_row("after_disabled",  9,   0, 0,  -1, 0,  1, 0,  0);
		total_bits = 0;
		foreach (t_bytes[i])
			total_bits += (t_bytes[i] + 2) * 10 + 3 * 8 + 8 + 16; // worst stuffing
		limit = 2 * total_bits * CLKS_PER_BIT + 400;
		wb_rst_i = 1'b1;
		rx_i = 1'b1;
		rx_en_i = 1'b1;
		restart_i = 1'b0;
		repeat (4) @(posedge clk);
		wb_rst_i <= 1'b0;
		foreach (t_name[i])
			run_test(i);
		$display("%0d tests, %0d failed, %0d mismatches", t_name.size(), failed_tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- verilog.f
common/irda_pkg.sv
common/mir_rx_if.sv
irda_mir_rx/irda_mir_line_det.sv
irda_mir_rx/irda_mir_bit_destuffer.sv
irda_mir_rx/irda_crc_rx_ccitt16.sv
irda_mir_rx/irda_mir_rx.sv
rtl/irda_mir_ctrl.sv
rtl/irda_mir_rx_top.sv
tb/irda_mir_rx_sva.sv
tb/irda_mir_rx_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = irda_mir_rx_tb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
